//--- verilog.f
+incdir+hdl
+incdir+testbench
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/subword_store_sequencer.sv
hdl/register_file.sv
hdl/store_execute.sv
hdl/data_memory.sv
hdl/mips_store_top.sv
testbench/tb_mips_store.sv

//--- testbench/tb_mips_store_model.svh
// reference model: expected memory and register contents, store and load prediction tasks
`ifndef TB_MIPS_STORE_MODEL_SVH
`define TB_MIPS_STORE_MODEL_SVH

word_t model_mem [`MIPS_MEM_WORDS];
word_t model_rf  [`MIPS_REG_COUNT];

task automatic model_clear();
  for (int i = 0; i < `MIPS_MEM_WORDS; i++) begin
    model_mem[i] = '0;
  end
  for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
    model_rf[i] = '0;
  end
endtask

// r0 keeps reading zero
task automatic model_reg_write(input reg_idx_t idx, input word_t val);
  if (idx != '0) begin
    model_rf[idx] = val;
  end
endtask

function automatic word_t model_ea(input reg_idx_t rs, input imm_t imm);
  return model_rf[rs] + {{16{imm[15]}}, imm};
endfunction

// little endian lanes, lane n holds bits 8n+7 down to 8n
task automatic model_store(input instr_t ins, output store_rec_t rec);
  word_t                   ea;
  word_t                   mask;
  int                      shift;
  logic [`MIPS_MEM_AW-1:0] idx;
  ea    = model_ea(ins.rs, ins.imm);
  idx   = ea[`MIPS_MEM_AW+1:2];
  mask  = 32'hffff_ffff;
  shift = 0;
  if (ins.opcode == OP_SB) begin
    shift = 8 * ea[1:0];
    mask  = 32'h0000_00ff << shift;
  end else if (ins.opcode == OP_SH) begin
    // address bit 0 plays no part for a halfword
    shift = 16 * ea[1];
    mask  = 32'h0000_ffff << shift;
  end
  model_mem[idx] = (model_mem[idx] & ~mask) | ((model_rf[ins.rt] << shift) & mask);
  rec.valid = 1'b1;
  rec.addr  = idx;
  rec.data  = model_mem[idx];
endtask

task automatic model_load(input instr_t ins, output word_t val);
  word_t ea;
  ea = model_ea(ins.rs, ins.imm);
  model_reg_write(ins.rt, model_mem[ea[`MIPS_MEM_AW+1:2]]);
  val = model_rf[ins.rt];
endtask

`endif

//--- testbench/tb_mips_store.sv
// testbench for the memory-access subsystem: clock, reset, stimulus, assertions, watchdog
`timescale 1ns/1ps
`include "mips_mem_cfg.svh"

module tb_mips_store;
  import isa_pkg::*;
  import pipe_pkg::*;

  `include "tb_mips_store_model.svh"

  localparam int N_SW   = 8;
  localparam int N_SB   = 8;
  localparam int N_SH   = 4;
  localparam int N_PAIR = 4;
  // every sb and sh is followed by one instruction that must be dropped
  localparam int N_ISSUED        = N_SW + 2 * N_SB + 2 * N_SH + 2 * N_PAIR;
  localparam int WATCHDOG_CYCLES = N_ISSUED * 4 + 50;

  // expected DUT outputs for one clock cycle
  typedef struct packed {
    store_rec_t st;
    logic       stall;
    logic       dbg_chk;
    reg_idx_t   dbg_idx;
    word_t      dbg_val;
  } exp_slot_t;

  logic       clk;
  logic       reset;
  logic       instr_valid;
  instr_t     instr;
  logic       reg_we;
  reg_idx_t   reg_wa;
  word_t      reg_wd;
  reg_idx_t   dbg_ra;
  logic       stall;
  word_t      dbg_rd;
  store_rec_t store_out;

  exp_slot_t ring [16];
  exp_slot_t exp_now;
  int        cyc;
  integer    seed;

  mips_store_top i_dut (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .reg_we      (reg_we),
    .reg_wa      (reg_wa),
    .reg_wd      (reg_wd),
    .dbg_ra      (dbg_ra),
    .stall       (stall),
    .dbg_rd      (dbg_rd),
    .store_out   (store_out)
  );

  always #4 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    abort_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  a_stall: assert property (@(posedge clk) disable iff (reset) stall == exp_now.stall)
    else report_mismatch("stall", $sampled(stall), exp_now.stall);
  a_st_valid: assert property (@(posedge clk) disable iff (reset)
                               store_out.valid == exp_now.st.valid)
    else report_mismatch("store_out.valid", $sampled(store_out.valid), exp_now.st.valid);
  a_st_addr: assert property (@(posedge clk) disable iff (reset)
                              exp_now.st.valid |-> store_out.addr == exp_now.st.addr)
    else report_mismatch("store_out.addr", $sampled(store_out.addr), exp_now.st.addr);
  a_st_data: assert property (@(posedge clk) disable iff (reset)
                              exp_now.st.valid |-> store_out.data == exp_now.st.data)
    else report_mismatch("store_out.data", $sampled(store_out.data), exp_now.st.data);
  a_dbg: assert property (@(posedge clk) disable iff (reset)
                          exp_now.dbg_chk |-> dbg_rd == exp_now.dbg_val)
    else report_mismatch("dbg_rd", $sampled(dbg_rd), exp_now.dbg_val);

  // advance one cycle, drive 1 ns after the edge and load that cycle's expectations
  task automatic tick();
    @(posedge clk);
    #1;
    cyc = cyc + 1;
    exp_now = ring[cyc % 16];
    ring[cyc % 16] = '0;
    instr_valid = 1'b0;
    reg_we = 1'b0;
    if (exp_now.dbg_chk) begin
      dbg_ra = exp_now.dbg_idx;
    end
  endtask

  function automatic reg_idx_t rand_reg();
    return reg_idx_t'(1 + {$random(seed)} % 8);
  endfunction

  task automatic load_reg(input reg_idx_t idx, input word_t val);
    reg_we = 1'b1;
    reg_wa = idx;
    reg_wd = val;
    model_reg_write(idx, val);
    tick();
  endtask

  task automatic check_reg(input reg_idx_t idx);
    ring[(cyc + 1) % 16].dbg_chk = 1'b1;
    ring[(cyc + 1) % 16].dbg_idx = idx;
    ring[(cyc + 1) % 16].dbg_val = model_rf[idx];
    tick();
  endtask

  task automatic issue(input opcode_e op, input reg_idx_t rs, input reg_idx_t rt,
                       input imm_t imm);
    instr_t     ins;
    store_rec_t rec;
    word_t      val;
    int         d;
    ins.opcode = op;
    ins.rs = rs;
    ins.rt = rt;
    ins.imm = imm;
    if (stall) begin
      abort_run("stall still high when a new instruction was due");
    end
    case (op)
      OP_LW: begin
        model_load(ins, val);
        ring[(cyc + 3) % 16].dbg_chk = 1'b1;
        ring[(cyc + 3) % 16].dbg_idx = rt;
        ring[(cyc + 3) % 16].dbg_val = val;
      end
      OP_SW: begin
        model_store(ins, rec);
        ring[(cyc + 3) % 16].st = rec;
      end
      OP_SB, OP_SH: begin
        model_store(ins, rec);
        ring[(cyc + 5) % 16].st = rec;
        for (d = 1; d <= 3; d++) begin
          ring[(cyc + d) % 16].stall = 1'b1;
        end
      end
      default: begin
        abort_run("stimulus asked for an opcode the subsystem does not handle");
      end
    endcase
    instr_valid = 1'b1;
    instr = ins;
    tick();
    if (op == OP_SB || op == OP_SH) begin
      // offered during stall, so it must leave no trace
      instr_valid = 1'b1;
      instr.opcode = OP_SW;
      instr.rs = rand_reg();
      instr.rt = rand_reg();
      instr.imm = 16'($random(seed));
      tick();
      while (stall) begin
        tick();
      end
    end
  endtask

  initial begin
    int                      i;
    imm_t                    imm;
    reg_idx_t                rs;
    reg_idx_t                rt;
    word_t                   ea;
    logic [`MIPS_MEM_AW-1:0] sw_idx [N_SW];
    seed = 32'h6734d977;
    clk = 1'b0;
    reset = 1'b1;
    instr_valid = 1'b0;
    instr = '0;
    reg_we = 1'b0;
    reg_wa = '0;
    reg_wd = '0;
    dbg_ra = '0;
    cyc = 0;
    exp_now = '0;
    for (i = 0; i < 16; i++) begin
      ring[i] = '0;
    end
    model_clear();
    repeat (4) tick();
    reset = 1'b0;
    for (i = 0; i < `MIPS_REG_COUNT; i++) begin
      check_reg(reg_idx_t'(i));
    end
    // r0 must ignore the load port
    load_reg('0, $random(seed));
    for (i = 1; i <= 8; i++) begin
      load_reg(reg_idx_t'(i), $random(seed));
    end
    for (i = 0; i <= 8; i++) begin
      check_reg(reg_idx_t'(i));
    end
    // remember which words the sw stores fill
    for (i = 0; i < N_SW; i++) begin
      rs = rand_reg();
      imm = 16'($random(seed));
      ea = model_ea(rs, imm);
      sw_idx[i] = ea[`MIPS_MEM_AW+1:2];
      issue(OP_SW, rs, rand_reg(), imm);
    end
    // sb lands on a word written above so the untouched lanes hold data
    for (i = 0; i < N_SB; i++) begin
      rs = rand_reg();
      imm = 16'($random(seed));
      imm[`MIPS_MEM_AW+1:0] = {sw_idx[i], imm[1:0]} - model_rf[rs][`MIPS_MEM_AW+1:0];
      issue(OP_SB, rs, rand_reg(), imm);
    end
    // alternate lower and upper half
    for (i = 0; i < N_SH; i++) begin
      rs = rand_reg();
      imm = 16'($random(seed));
      imm[`MIPS_MEM_AW+1:0] = {sw_idx[i], i[0], imm[0]} - model_rf[rs][`MIPS_MEM_AW+1:0];
      issue(OP_SH, rs, rand_reg(), imm);
    end
    // lw reads back the word just stored, into another register
    for (i = 0; i < N_PAIR; i++) begin
      rs = rand_reg();
      rt = rand_reg();
      imm = 16'($random(seed));
      issue(OP_SW, rs, rt, imm);
      issue(OP_LW, rs, reg_idx_t'(rt % 8 + 1), imm);
    end
    repeat (8) tick();
    $display("=== PASS ===");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run($sformatf("timeout, run not finished after %0d cycles", WATCHDOG_CYCLES));
  end

endmodule

//--- hdl/mips_store_top.sv
// top level of the memory-access subsystem: sequencer, register file, execute, data memory
`timescale 1ns/1ps
`include "mips_mem_cfg.svh"

module mips_store_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 instr_valid,
  input  isa_pkg::instr_t      instr,
  input  logic                 reg_we,
  input  isa_pkg::reg_idx_t    reg_wa,
  input  isa_pkg::word_t       reg_wd,
  input  isa_pkg::reg_idx_t    dbg_ra,
  output logic                 stall,
  output isa_pkg::word_t       dbg_rd,
  output pipe_pkg::store_rec_t store_out
);
  import isa_pkg::*;
  import pipe_pkg::*;

  uop_t                    uop;
  word_t                   rs_val;
  word_t                   rt_val;
  word_t                   scr_q;
  logic                    wb_we;
  reg_idx_t                wb_idx;
  word_t                   wb_data;
  logic                    scr_we;
  word_t                   scr_data;
  logic [`MIPS_MEM_AW-1:0] mem_addr;
  word_t                   mem_rdata;
  logic                    mem_we;
  word_t                   mem_wdata;

  subword_store_sequencer i_seq (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .stall       (stall),
    .uop         (uop)
  );

  // rs and rt of the current uop feed the two read ports
  register_file i_rf (
    .clk      (clk),
    .reset    (reset),
    .ra1      (uop.base),
    .ra2      (uop.rt),
    .rd1      (rs_val),
    .rd2      (rt_val),
    .wb_we    (wb_we),
    .wb_idx   (wb_idx),
    .wb_data  (wb_data),
    .reg_we   (reg_we),
    .reg_wa   (reg_wa),
    .reg_wd   (reg_wd),
    .scr_we   (scr_we),
    .scr_data (scr_data),
    .scr_q    (scr_q),
    .dbg_ra   (dbg_ra),
    .dbg_rd   (dbg_rd)
  );

  store_execute i_exe (
    .uop       (uop),
    .rs_val    (rs_val),
    .rt_val    (rt_val),
    .scr_q     (scr_q),
    .mem_rdata (mem_rdata),
    .mem_addr  (mem_addr),
    .wb_we     (wb_we),
    .wb_idx    (wb_idx),
    .wb_data   (wb_data),
    .scr_we    (scr_we),
    .scr_data  (scr_data),
    .mem_we    (mem_we),
    .mem_wdata (mem_wdata)
  );

  data_memory i_dmem (
    .clk       (clk),
    .reset     (reset),
    .addr      (mem_addr),
    .we        (mem_we),
    .wdata     (mem_wdata),
    .rdata     (mem_rdata),
    .store_out (store_out)
  );

endmodule

//--- hdl/data_memory.sv
// data memory: word array with async read, sync write and a registered store record
`timescale 1ns/1ps
`include "mips_mem_cfg.svh"

module data_memory (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`MIPS_MEM_AW-1:0] addr,
  input  logic                    we,
  input  isa_pkg::word_t          wdata,
  output isa_pkg::word_t          rdata,
  output pipe_pkg::store_rec_t    store_out
);
  import isa_pkg::*;

  word_t mem [`MIPS_MEM_WORDS];

  // whole array starts from zero after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `MIPS_MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      mem[addr] <= wdata;
    end
  end

  assign rdata = mem[addr];

  // one-cycle pulse per write, payload kept until the next write
  always_ff @(posedge clk) begin
    if (reset) begin
      store_out.valid <= 1'b0;
    end else begin
      store_out.valid <= we;
      if (we) begin
        store_out.addr <= addr;
        store_out.data <= wdata;
      end
    end
  end

endmodule

//--- hdl/store_execute.sv
// execute stage: address generation, byte/halfword merge, writeback and store routing
`timescale 1ns/1ps
`include "mips_mem_cfg.svh"

module store_execute (
  input  pipe_pkg::uop_t          uop,
  input  isa_pkg::word_t          rs_val,
  input  isa_pkg::word_t          rt_val,
  input  isa_pkg::word_t          scr_q,
  input  isa_pkg::word_t          mem_rdata,
  output logic [`MIPS_MEM_AW-1:0] mem_addr,
  output logic                    wb_we,
  output isa_pkg::reg_idx_t       wb_idx,
  output isa_pkg::word_t          wb_data,
  output logic                    scr_we,
  output isa_pkg::word_t          scr_data,
  output logic                    mem_we,
  output isa_pkg::word_t          mem_wdata
);
  import isa_pkg::*;
  import pipe_pkg::*;

  word_t      eff_addr;
  logic [1:0] byte_off;
  word_t      byte_merged;
  word_t      half_merged;

  // base plus sign-extended offset
  assign eff_addr = rs_val + {{(`MIPS_DATA_W-16){uop.imm[15]}}, uop.imm};
  assign mem_addr = eff_addr[`MIPS_MEM_AW+1:2];
  assign byte_off = eff_addr[1:0];

  // little endian lanes, lane n is bits 8n+7:8n
  // halfword position comes from address bit 1 only
  always_comb begin
    byte_merged = scr_q;
    half_merged = scr_q;
    byte_merged[{byte_off, 3'b000} +: 8]    = rt_val[7:0];
    half_merged[{byte_off[1], 4'b0000} +: 16] = rt_val[15:0];
  end

  // per-kind write enables and data steering
  always_comb begin
    wb_we     = 1'b0;
    wb_idx    = uop.rt;
    wb_data   = mem_rdata;
    scr_we    = 1'b0;
    scr_data  = mem_rdata;
    mem_we    = 1'b0;
    mem_wdata = rt_val;

    case (uop.kind)
      UOP_LW: begin
        wb_we = 1'b1;
      end
      UOP_SW: begin
        mem_we = 1'b1;
      end
      UOP_LOAD_SCR: begin
        scr_we = 1'b1;
      end
      UOP_MERGE_B: begin
        scr_we   = 1'b1;
        scr_data = byte_merged;
      end
      UOP_MERGE_H: begin
        scr_we   = 1'b1;
        scr_data = half_merged;
      end
      UOP_STORE_SCR: begin
        mem_we    = 1'b1;
        mem_wdata = scr_q;
      end
      default: begin
        // UOP_NONE, bubble
        wb_we  = 1'b0;
        scr_we = 1'b0;
        mem_we = 1'b0;
      end
    endcase
  end

endmodule

//--- hdl/register_file.sv
// register file: 32 registers with r0 at zero, scratch register, load port, debug read
`timescale 1ns/1ps
`include "mips_mem_cfg.svh"

module register_file (
  input  logic              clk,
  input  logic              reset,
  input  isa_pkg::reg_idx_t ra1,
  input  isa_pkg::reg_idx_t ra2,
  output isa_pkg::word_t    rd1,
  output isa_pkg::word_t    rd2,
  input  logic              wb_we,
  input  isa_pkg::reg_idx_t wb_idx,
  input  isa_pkg::word_t    wb_data,
  input  logic              reg_we,
  input  isa_pkg::reg_idx_t reg_wa,
  input  isa_pkg::word_t    reg_wd,
  input  logic              scr_we,
  input  isa_pkg::word_t    scr_data,
  output isa_pkg::word_t    scr_q,
  input  isa_pkg::reg_idx_t dbg_ra,
  output isa_pkg::word_t    dbg_rd
);
  import isa_pkg::*;

  word_t rf [`MIPS_REG_COUNT];
  word_t scr;

  // pipeline writeback wins over the load port
  // r0 is cleared at reset and never written, so it always reads zero
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
        rf[i] <= '0;
      end
    end else if (wb_we) begin
      if (wb_idx != '0) begin
        rf[wb_idx] <= wb_data;
      end
    end else if (reg_we) begin
      if (reg_wa != '0) begin
        rf[reg_wa] <= reg_wd;
      end
    end
  end

  // hidden scratch word used by the sb/sh expansion
  always_ff @(posedge clk) begin
    if (reset) begin
      scr <= '0;
    end else if (scr_we) begin
      scr <= scr_data;
    end
  end

  // combinational reads
  assign rd1    = rf[ra1];
  assign rd2    = rf[ra2];
  assign scr_q  = scr;
  assign dbg_rd = rf[dbg_ra];

endmodule

//--- hdl/subword_store_sequencer.sv
// sub-word store sequencer: instruction register, decode FSM, stall and micro-op register
`timescale 1ns/1ps

module subword_store_sequencer (
  input  logic            clk,
  input  logic            reset,
  input  logic            instr_valid,
  input  isa_pkg::instr_t instr,
  output logic            stall,
  output pipe_pkg::uop_t  uop
);
  import isa_pkg::*;
  import pipe_pkg::*;

  instr_t     ir;
  logic       ir_valid;
  logic       ir_is_sub;
  seq_state_e state;
  seq_state_e state_next;
  uop_t       uop_next;

  // capture an instruction only when not stalled
  // while stalled ir is frozen and supplies rs, rt and imm to the later micro-ops
  always_ff @(posedge clk) begin
    if (reset) begin
      ir_valid <= 1'b0;
      ir       <= '0;
    end else begin
      ir_valid <= instr_valid & ~stall;
      if (instr_valid && !stall) begin
        ir <= instr;
      end
    end
  end

  // sb or sh sitting in ir and not yet started
  assign ir_is_sub = ir_valid && (ir.opcode == OP_SB || ir.opcode == OP_SH);

  // stall covers the decode cycle of sb/sh and the two cycles that follow
  assign stall = (state == SEQ_IDLE) ? ir_is_sub : 1'b1;

  always_comb begin
    state_next    = state;
    uop_next.base = ir.rs;
    uop_next.rt   = ir.rt;
    uop_next.imm  = ir.imm;
    uop_next.kind = UOP_NONE;

    case (state)
      SEQ_IDLE: begin
        if (ir_valid) begin
          case (ir.opcode)
            OP_LW: begin
              uop_next.kind = UOP_LW;
            end
            OP_SW: begin
              uop_next.kind = UOP_SW;
            end
            OP_SB, OP_SH: begin
              // first step: fetch the target word into scratch
              uop_next.kind = UOP_LOAD_SCR;
              state_next    = SEQ_MERGE;
            end
            default: begin
              uop_next.kind = UOP_NONE;
            end
          endcase
        end
      end

      SEQ_MERGE: begin
        if (ir.opcode == OP_SH) begin
          uop_next.kind = UOP_MERGE_H;
        end else begin
          uop_next.kind = UOP_MERGE_B;
        end
        state_next = SEQ_STORE;
      end

      SEQ_STORE: begin
        // write the merged scratch word back
        uop_next.kind = UOP_STORE_SCR;
        state_next    = SEQ_IDLE;
      end

      default: begin
        state_next = SEQ_IDLE;
      end
    endcase
  end

  // micro-op register, one uop per cycle into execute
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= SEQ_IDLE;
      uop   <= '0;
    end else begin
      state <= state_next;
      uop   <= uop_next;
    end
  end

endmodule

//--- hdl/pipe_pkg.sv
// pipeline types: micro-op kinds and record, sequencer states, store observation record
`include "mips_mem_cfg.svh"

package pipe_pkg;
  import isa_pkg::*;

  // micro-operations issued to the execute stage
  // sb and sh expand into LOAD_SCR, MERGE_B or MERGE_H, STORE_SCR
  typedef enum logic [2:0] {
    UOP_NONE,
    UOP_LW,
    UOP_SW,
    UOP_LOAD_SCR,
    UOP_MERGE_B,
    UOP_MERGE_H,
    UOP_STORE_SCR
  } uop_kind_e;

  // one micro-op, valid for a single cycle
  typedef struct packed {
    uop_kind_e kind;
    reg_idx_t  base;
    reg_idx_t  rt;
    imm_t      imm;
  } uop_t;

  // sub-word expansion FSM
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_MERGE,
    SEQ_STORE
  } seq_state_e;

  // record of one memory write, for observation outside the DUT
  typedef struct packed {
    logic                    valid;
    logic [`MIPS_MEM_AW-1:0] addr;
    word_t                   data;
  } store_rec_t;

endpackage

//--- hdl/isa_pkg.sv
// instruction set types: field widths, opcode encoding and the instruction word layout
`include "mips_mem_cfg.svh"

package isa_pkg;

  // one data word as held in registers and memory
  typedef logic [`MIPS_DATA_W-1:0] word_t;

  // register index, selects one of 32 registers
  typedef logic [4:0] reg_idx_t;

  // immediate offset field, sign extended at address generation
  typedef logic [15:0] imm_t;

  // memory opcodes handled by the subsystem
  // anything else in the opcode field is treated as a no-op
  typedef enum logic [5:0] {
    OP_LW = 6'b100011,
    OP_SW = 6'b101011,
    OP_SB = 6'b101000,
    OP_SH = 6'b101001
  } opcode_e;

  // I-type instruction word
  //   [31:26] opcode
  //   [25:21] rs, base register
  //   [20:16] rt, data source or load target
  //   [15:0]  imm, signed byte offset
  typedef struct packed {
    opcode_e  opcode;
    reg_idx_t rs;
    reg_idx_t rt;
    imm_t     imm;
  } instr_t;

endpackage

//--- hdl/mips_mem_cfg.svh
// size macros for the memory-access subsystem: data width, register count, memory geometry
`ifndef MIPS_MEM_CFG_SVH
`define MIPS_MEM_CFG_SVH

// width of a data word and of every register
`define MIPS_DATA_W 32

// architectural registers, r0 included
`define MIPS_REG_COUNT 32

// data memory depth in words
`define MIPS_MEM_WORDS 64

// word index into data memory, log2 of the depth
`define MIPS_MEM_AW 6

`endif
